/* frontend_pkg.sv */
package frontend_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int FETCH_WIDTH    = 4;
    localparam int INST_WIDTH     = 32;
    localparam int CLASS_WIDTH    = 3;
    localparam int REG_WIDTH      = 5;
    localparam int OPERAND_WIDTH  = 12;
    // Lane counts 0 to FETCH_WIDTH
    localparam int COUNT_WIDTH    = 3;
    localparam int CFG_ADDR_WIDTH = 2;
    localparam int CFG_DATA_WIDTH = 32;

    // Instruction classes
    localparam logic [CLASS_WIDTH-1:0] CLASS_OTHER   = 3'd0;
    localparam logic [CLASS_WIDTH-1:0] CLASS_ALU_REG = 3'd1;
    localparam logic [CLASS_WIDTH-1:0] CLASS_ALU_IMM = 3'd2;
    localparam logic [CLASS_WIDTH-1:0] CLASS_LOAD    = 3'd3;
    localparam logic [CLASS_WIDTH-1:0] CLASS_STORE   = 3'd4;
    localparam logic [CLASS_WIDTH-1:0] CLASS_BRANCH  = 3'd5;

    // RISC-V major opcodes
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;

    // Config register map
    localparam logic [CFG_ADDR_WIDTH-1:0] REG_DISPATCH_LIMIT   = 2'd0;
    localparam logic [CFG_ADDR_WIDTH-1:0] REG_DISPATCHED_COUNT = 2'd1;
    localparam logic [CFG_ADDR_WIDTH-1:0] REG_OCCUPANCY        = 2'd2;

    ////////////////////////////////////////
    // Instruction word in register or immediate layout
    ////////////////////////////////////////
    typedef union packed {
        struct packed {
            logic [6:0]           funct7;
            logic [REG_WIDTH-1:0] rs2;
            logic [REG_WIDTH-1:0] rs1;
            logic [2:0]           funct3;
            logic [REG_WIDTH-1:0] rd;
            logic [6:0]           opcode;
        } r_view;
        struct packed {
            logic [11:0]          imm;
            logic [REG_WIDTH-1:0] rs1;
            logic [2:0]           funct3;
            logic [REG_WIDTH-1:0] rd;
            logic [6:0]           opcode;
        } i_view;
    } inst_word_t;

endpackage

/* fetch_buffer.sv */
`timescale 1ns/1ps

module fetch_buffer
    import frontend_pkg::*;
#(
    parameter int BUFFER_DEPTH = 16
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [FETCH_WIDTH*INST_WIDTH-1:0]   inst_value,
    input  logic [FETCH_WIDTH-1:0]              inst_valid,
    input  logic [COUNT_WIDTH-1:0]              pop_count,
    output logic [FETCH_WIDTH*INST_WIDTH-1:0]   head_inst,
    output logic [COUNT_WIDTH-1:0]              head_count,
    output logic [$clog2(BUFFER_DEPTH):0]       occupancy,
    output logic [COUNT_WIDTH-1:0]              fetch_credit_return
);

    localparam int PTR_W = $clog2(BUFFER_DEPTH);
    localparam int OCC_W = PTR_W + 1;

    logic [INST_WIDTH-1:0]  mem [BUFFER_DEPTH];
    logic [PTR_W-1:0]       front;
    logic [PTR_W-1:0]       rear;
    logic [COUNT_WIDTH-1:0] push_count;
    logic [PTR_W-1:0]       write_addr [FETCH_WIDTH];

    ////////////////////////////////////////
    // Enqueue side
    ////////////////////////////////////////

    // Each valid lane lands after the valid lanes below it
    always_comb begin
        push_count = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            write_addr[i] = rear + PTR_W'(push_count);
            push_count    = push_count + COUNT_WIDTH'(inst_valid[i]);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (inst_valid[i]) begin
                mem[write_addr[i]] <= inst_value[i*INST_WIDTH +: INST_WIDTH];
            end
        end
    end

    ////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            front     <= '0;
            rear      <= '0;
            occupancy <= '0;
        end else begin
            // Pointers wrap on their own since depth is a power of two
            front     <= front + PTR_W'(pop_count);
            rear      <= rear + PTR_W'(push_count);
            occupancy <= occupancy + OCC_W'(push_count) - OCC_W'(pop_count);
        end
    end

    // Entries popped at this edge go back to fetch as credits
    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_credit_return <= '0;
        end else begin
            fetch_credit_return <= pop_count;
        end
    end

    ////////////////////////////////////////
    // Dequeue side
    ////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            head_inst[i*INST_WIDTH +: INST_WIDTH] = mem[front + PTR_W'(i)];
        end
    end

    // Lanes past the occupancy hold stale words and are not counted
    always_comb begin
        if (occupancy > OCC_W'(FETCH_WIDTH)) begin
            head_count = COUNT_WIDTH'(FETCH_WIDTH);
        end else begin
            head_count = COUNT_WIDTH'(occupancy);
        end
    end

endmodule

/* inst_predecode.sv */
`timescale 1ns/1ps

module inst_predecode
    import frontend_pkg::*;
(
    input  logic                                clock,
    input  logic                                reset,
    input  logic [FETCH_WIDTH*INST_WIDTH-1:0]   head_inst,
    input  logic [COUNT_WIDTH-1:0]              pop_count,
    output logic [FETCH_WIDTH-1:0]              dispatch_valid,
    output logic [FETCH_WIDTH*CLASS_WIDTH-1:0]  dispatch_class,
    output logic [FETCH_WIDTH*REG_WIDTH-1:0]    dispatch_rd,
    output logic [FETCH_WIDTH*REG_WIDTH-1:0]    dispatch_rs1,
    output logic [FETCH_WIDTH*OPERAND_WIDTH-1:0] dispatch_operand
);

    inst_word_t               lane_word    [FETCH_WIDTH];
    logic [CLASS_WIDTH-1:0]   lane_class   [FETCH_WIDTH];
    logic [OPERAND_WIDTH-1:0] lane_operand [FETCH_WIDTH];

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            lane_word[i] = head_inst[i*INST_WIDTH +: INST_WIDTH];

            // Class from the major opcode
            case (lane_word[i].r_view.opcode)
                OPCODE_OP:     lane_class[i] = CLASS_ALU_REG;
                OPCODE_OP_IMM: lane_class[i] = CLASS_ALU_IMM;
                OPCODE_LOAD:   lane_class[i] = CLASS_LOAD;
                OPCODE_STORE:  lane_class[i] = CLASS_STORE;
                OPCODE_BRANCH: lane_class[i] = CLASS_BRANCH;
                default:       lane_class[i] = CLASS_OTHER;
            endcase

            // Register forms carry rs2 and immediate forms carry imm
            case (lane_class[i])
                CLASS_ALU_REG, CLASS_STORE, CLASS_BRANCH:
                    lane_operand[i] = OPERAND_WIDTH'(lane_word[i].r_view.rs2);
                CLASS_ALU_IMM, CLASS_LOAD:
                    lane_operand[i] = lane_word[i].i_view.imm;
                default:
                    lane_operand[i] = '0;
            endcase
        end
    end

    // Popped lanes are always the lowest ones
    always_ff @(posedge clock) begin
        if (reset) begin
            dispatch_valid <= '0;
        end else begin
            for (int i = 0; i < FETCH_WIDTH; i++) begin
                dispatch_valid[i] <= (COUNT_WIDTH'(i) < pop_count);
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            dispatch_class[i*CLASS_WIDTH +: CLASS_WIDTH]       <= lane_class[i];
            dispatch_rd[i*REG_WIDTH +: REG_WIDTH]              <= lane_word[i].r_view.rd;
            dispatch_rs1[i*REG_WIDTH +: REG_WIDTH]             <= lane_word[i].r_view.rs1;
            dispatch_operand[i*OPERAND_WIDTH +: OPERAND_WIDTH] <= lane_operand[i];
        end
    end

endmodule

/* dispatch_control.sv */
`timescale 1ns/1ps

module dispatch_control
    import frontend_pkg::*;
#(
    parameter int BACKEND_CREDITS = 8
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [COUNT_WIDTH-1:0] head_count,
    input  logic [2:0]             dispatch_limit,
    input  logic [COUNT_WIDTH-1:0] backend_credit_return,
    output logic [COUNT_WIDTH-1:0] pop_count
);

    // At least wide enough to hold a full lane count
    localparam int CREDIT_W = ($clog2(BACKEND_CREDITS + 1) > COUNT_WIDTH) ?
                              $clog2(BACKEND_CREDITS + 1) : COUNT_WIDTH;

    logic [CREDIT_W-1:0]    credits;
    logic [COUNT_WIDTH-1:0] credit_cap;
    logic [COUNT_WIDTH-1:0] limit_cap;
    logic [COUNT_WIDTH-1:0] pick;

    ////////////////////////////////////////
    // Back-end credit counter
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            credits <= CREDIT_W'(BACKEND_CREDITS);
        end else begin
            credits <= credits + CREDIT_W'(backend_credit_return) - CREDIT_W'(pop_count);
        end
    end

    ////////////////////////////////////////
    // Pop count as the smallest of the four limits
    ////////////////////////////////////////
    always_comb begin
        if (credits > CREDIT_W'(FETCH_WIDTH)) begin
            credit_cap = COUNT_WIDTH'(FETCH_WIDTH);
        end else begin
            credit_cap = credits[COUNT_WIDTH-1:0];
        end

        // Limits 5 to 7 behave as 4
        if (dispatch_limit > 3'(FETCH_WIDTH)) begin
            limit_cap = COUNT_WIDTH'(FETCH_WIDTH);
        end else begin
            limit_cap = dispatch_limit;
        end

        pick = head_count;
        if (credit_cap < pick) begin
            pick = credit_cap;
        end
        if (limit_cap < pick) begin
            pick = limit_cap;
        end
        pop_count = pick;
    end

endmodule

/* frontend_config.sv */
`timescale 1ns/1ps

module frontend_config
    import frontend_pkg::*;
#(
    parameter int BUFFER_DEPTH = 16
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          cfg_write,
    input  logic [CFG_ADDR_WIDTH-1:0]     cfg_address,
    input  logic [CFG_DATA_WIDTH-1:0]     cfg_write_data,
    input  logic [COUNT_WIDTH-1:0]        pop_count,
    input  logic [$clog2(BUFFER_DEPTH):0] occupancy,
    output logic [2:0]                    dispatch_limit,
    output logic [CFG_DATA_WIDTH-1:0]     cfg_read_data
);

    logic [CFG_DATA_WIDTH-1:0] dispatched_count;

    // Only the limit is writable
    always_ff @(posedge clock) begin
        if (reset) begin
            dispatch_limit <= 3'(FETCH_WIDTH);
        end else if (cfg_write && (cfg_address == REG_DISPATCH_LIMIT)) begin
            dispatch_limit <= cfg_write_data[2:0];
        end
    end

    // Running total of dispatched instructions that wraps at 32 bits
    always_ff @(posedge clock) begin
        if (reset) begin
            dispatched_count <= '0;
        end else begin
            dispatched_count <= dispatched_count + CFG_DATA_WIDTH'(pop_count);
        end
    end

    ////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////
    always_comb begin
        case (cfg_address)
            REG_DISPATCH_LIMIT:   cfg_read_data = CFG_DATA_WIDTH'(dispatch_limit);
            REG_DISPATCHED_COUNT: cfg_read_data = dispatched_count;
            REG_OCCUPANCY:        cfg_read_data = CFG_DATA_WIDTH'(occupancy);
            default:              cfg_read_data = '0;
        endcase
    end

endmodule

/* ria_frontend.sv */
`timescale 1ns/1ps

module ria_frontend
    import frontend_pkg::*;
#(
    parameter int BUFFER_DEPTH    = 16,
    parameter int BACKEND_CREDITS = 8
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [FETCH_WIDTH*INST_WIDTH-1:0]    inst_value,
    input  logic [FETCH_WIDTH-1:0]               inst_valid,
    input  logic [COUNT_WIDTH-1:0]               backend_credit_return,
    input  logic                                 cfg_write,
    input  logic [CFG_ADDR_WIDTH-1:0]            cfg_address,
    input  logic [CFG_DATA_WIDTH-1:0]            cfg_write_data,
    output logic [COUNT_WIDTH-1:0]               fetch_credit_return,
    output logic [FETCH_WIDTH-1:0]               dispatch_valid,
    output logic [FETCH_WIDTH*CLASS_WIDTH-1:0]   dispatch_class,
    output logic [FETCH_WIDTH*REG_WIDTH-1:0]     dispatch_rd,
    output logic [FETCH_WIDTH*REG_WIDTH-1:0]     dispatch_rs1,
    output logic [FETCH_WIDTH*OPERAND_WIDTH-1:0] dispatch_operand,
    output logic [CFG_DATA_WIDTH-1:0]            cfg_read_data
);

    logic [FETCH_WIDTH*INST_WIDTH-1:0] head_inst;
    logic [COUNT_WIDTH-1:0]            head_count;
    logic [$clog2(BUFFER_DEPTH):0]     occupancy;
    logic [COUNT_WIDTH-1:0]            pop_count;
    logic [2:0]                        dispatch_limit;

    fetch_buffer #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) fetch_buffer0 (
        .clock               (clock),
        .reset               (reset),
        .inst_value          (inst_value),
        .inst_valid          (inst_valid),
        .pop_count           (pop_count),
        .head_inst           (head_inst),
        .head_count          (head_count),
        .occupancy           (occupancy),
        .fetch_credit_return (fetch_credit_return)
    );

    inst_predecode inst_predecode0 (
        .clock            (clock),
        .reset            (reset),
        .head_inst        (head_inst),
        .pop_count        (pop_count),
        .dispatch_valid   (dispatch_valid),
        .dispatch_class   (dispatch_class),
        .dispatch_rd      (dispatch_rd),
        .dispatch_rs1     (dispatch_rs1),
        .dispatch_operand (dispatch_operand)
    );

    dispatch_control #(
        .BACKEND_CREDITS (BACKEND_CREDITS)
    ) dispatch_control0 (
        .clock                 (clock),
        .reset                 (reset),
        .head_count            (head_count),
        .dispatch_limit        (dispatch_limit),
        .backend_credit_return (backend_credit_return),
        .pop_count             (pop_count)
    );

    frontend_config #(
        .BUFFER_DEPTH (BUFFER_DEPTH)
    ) frontend_config0 (
        .clock          (clock),
        .reset          (reset),
        .cfg_write      (cfg_write),
        .cfg_address    (cfg_address),
        .cfg_write_data (cfg_write_data),
        .pop_count      (pop_count),
        .occupancy      (occupancy),
        .dispatch_limit (dispatch_limit),
        .cfg_read_data  (cfg_read_data)
    );

endmodule

/* frontend_tb.sv */
`timescale 1ns/1ps

module frontend_tb
    import frontend_pkg::*;
();

    localparam int BUFFER_DEPTH    = 16;
    localparam int BACKEND_CREDITS = 8;
    localparam int RESET_CYCLES    = 16;
    localparam int RUN_CYCLES      = 3000;
    localparam int DRAIN_START     = 2600;
    localparam int PHASE_LEN       = 200;
    // Reset plus run plus a margin
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + RUN_CYCLES + 984;

    logic                                 clock;
    logic                                 reset;
    logic [FETCH_WIDTH*INST_WIDTH-1:0]    inst_value;
    logic [FETCH_WIDTH-1:0]               inst_valid;
    logic [COUNT_WIDTH-1:0]               backend_credit_return;
    logic                                 cfg_write;
    logic [CFG_ADDR_WIDTH-1:0]            cfg_address;
    logic [CFG_DATA_WIDTH-1:0]            cfg_write_data;
    logic [COUNT_WIDTH-1:0]               fetch_credit_return;
    logic [FETCH_WIDTH-1:0]               dispatch_valid;
    logic [FETCH_WIDTH*CLASS_WIDTH-1:0]   dispatch_class;
    logic [FETCH_WIDTH*REG_WIDTH-1:0]     dispatch_rd;
    logic [FETCH_WIDTH*REG_WIDTH-1:0]     dispatch_rs1;
    logic [FETCH_WIDTH*OPERAND_WIDTH-1:0] dispatch_operand;
    logic [CFG_DATA_WIDTH-1:0]            cfg_read_data;

    ////////////////////////////////////////
    // Model state
    ////////////////////////////////////////
    int                    seed;
    logic [INST_WIDTH-1:0] model_q [$];
    int                    fetch_credits;
    // Copy of the DUT back-end credit counter
    int                    backend_held;
    // Dispatched but not yet returned by the back end
    int                    backend_owed;
    int                    occ_model;
    int                    total_dispatched;
    logic [2:0]            limit_model;
    logic [2:0]            limit_used;
    int                    push_seen;
    int                    return_seen;

    ria_frontend #(
        .BUFFER_DEPTH    (BUFFER_DEPTH),
        .BACKEND_CREDITS (BACKEND_CREDITS)
    ) dut0 (
        .clock                 (clock),
        .reset                 (reset),
        .inst_value            (inst_value),
        .inst_valid            (inst_valid),
        .backend_credit_return (backend_credit_return),
        .cfg_write             (cfg_write),
        .cfg_address           (cfg_address),
        .cfg_write_data        (cfg_write_data),
        .fetch_credit_return   (fetch_credit_return),
        .dispatch_valid        (dispatch_valid),
        .dispatch_class        (dispatch_class),
        .dispatch_rd           (dispatch_rd),
        .dispatch_rs1          (dispatch_rs1),
        .dispatch_operand      (dispatch_operand),
        .cfg_read_data         (cfg_read_data)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    function automatic int count_lanes(input logic [FETCH_WIDTH-1:0] mask);
        int n;
        n = 0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            n += int'(mask[i]);
        end
        return n;
    endfunction

    function automatic int min_of(input int a, input int b);
        return (a < b) ? a : b;
    endfunction

    // Mostly known opcodes so every class shows up
    function automatic logic [INST_WIDTH-1:0] random_inst();
        logic [INST_WIDTH-1:0] word;
        int                    pick;
        word = $random(seed);
        pick = $unsigned($random(seed)) % 6;
        case (pick)
            0:       word[6:0] = OPCODE_OP;
            1:       word[6:0] = OPCODE_OP_IMM;
            2:       word[6:0] = OPCODE_LOAD;
            3:       word[6:0] = OPCODE_STORE;
            4:       word[6:0] = OPCODE_BRANCH;
            default: word[6:0] = word[6:0];
        endcase
        return word;
    endfunction

    // Expected predecode fields of one word
    task automatic predecode_model(input logic [INST_WIDTH-1:0] word,
                                   output logic [CLASS_WIDTH-1:0] cls,
                                   output logic [REG_WIDTH-1:0] rd,
                                   output logic [REG_WIDTH-1:0] rs1,
                                   output logic [OPERAND_WIDTH-1:0] operand);
        rd  = word[11:7];
        rs1 = word[19:15];
        case (word[6:0])
            OPCODE_OP:     cls = CLASS_ALU_REG;
            OPCODE_OP_IMM: cls = CLASS_ALU_IMM;
            OPCODE_LOAD:   cls = CLASS_LOAD;
            OPCODE_STORE:  cls = CLASS_STORE;
            OPCODE_BRANCH: cls = CLASS_BRANCH;
            default:       cls = CLASS_OTHER;
        endcase
        if (cls == CLASS_ALU_REG || cls == CLASS_STORE || cls == CLASS_BRANCH) begin
            operand = {7'b0, word[24:20]};
        end else if (cls == CLASS_ALU_IMM || cls == CLASS_LOAD) begin
            operand = word[31:20];
        end else begin
            operand = '0;
        end
    endtask

    task automatic report_error(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // What the DUT takes in at this edge
    task automatic sample_inputs();
        push_seen   = count_lanes(inst_valid);
        return_seen = int'(backend_credit_return);
        limit_used  = limit_model;
        if (cfg_write && cfg_address == REG_DISPATCH_LIMIT) begin
            limit_model = cfg_write_data[2:0];
        end
    endtask

    task automatic drive_inputs(input int cyc);
        logic [FETCH_WIDTH*INST_WIDTH-1:0] values;
        logic [FETCH_WIDTH-1:0]            mask;
        logic [CFG_DATA_WIDTH-1:0]         data;
        logic [CFG_ADDR_WIDTH-1:0]         addr;
        logic                              write;
        int                                ret;
        mask = '0;
        if (cyc < DRAIN_START) begin
            mask = FETCH_WIDTH'($random(seed));
            // Drop upper lanes until the mask fits the credits
            for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
                if (mask[i] && count_lanes(mask) > fetch_credits) begin
                    mask[i] = 1'b0;
                end
            end
        end
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            values[i*INST_WIDTH +: INST_WIDTH] = random_inst();
            if (mask[i]) begin
                model_q.push_back(values[i*INST_WIDTH +: INST_WIDTH]);
            end
        end
        fetch_credits -= count_lanes(mask);

        // Slow back end in every other window
        ret = $unsigned($random(seed)) % 5;
        if ((cyc / 250) % 2 == 1 && $unsigned($random(seed)) % 4 != 0) begin
            ret = 0;
        end
        if (cyc >= DRAIN_START) begin
            ret = FETCH_WIDTH;
        end
        ret = min_of(ret, backend_owed);
        backend_owed -= ret;

        data  = $random(seed);
        addr  = CFG_ADDR_WIDTH'($random(seed));
        write = ($unsigned($random(seed)) % 40 == 0) && addr != REG_DISPATCH_LIMIT;
        if (cyc == DRAIN_START) begin
            data[2:0] = 3'd4;
            addr      = REG_DISPATCH_LIMIT;
            write     = 1'b1;
        end else if (cyc < DRAIN_START && cyc % PHASE_LEN == 0) begin
            // Some phases pinned to a stall and to limits above 4
            case (cyc / PHASE_LEN)
                2:       data[2:0] = 3'd0;
                4:       data[2:0] = 3'd7;
                6:       data[2:0] = 3'd5;
                default: data[2:0] = data[2:0];
            endcase
            addr  = REG_DISPATCH_LIMIT;
            write = 1'b1;
        end

        inst_value            <= values;
        inst_valid            <= mask;
        backend_credit_return <= COUNT_WIDTH'(ret);
        cfg_write             <= write;
        cfg_address           <= addr;
        cfg_write_data        <= data;
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    task automatic check_outputs();
        int                        n;
        int                        expect_pop;
        logic [INST_WIDTH-1:0]     word;
        logic [CLASS_WIDTH-1:0]    cls;
        logic [REG_WIDTH-1:0]      rd;
        logic [REG_WIDTH-1:0]      rs1;
        logic [OPERAND_WIDTH-1:0]  operand;
        logic [CFG_DATA_WIDTH-1:0] expect_read;
        n          = count_lanes(dispatch_valid);
        expect_pop = min_of(min_of(occ_model, FETCH_WIDTH), min_of(backend_held, FETCH_WIDTH));
        expect_pop = min_of(expect_pop, min_of(int'(limit_used), FETCH_WIDTH));

        assert (dispatch_valid == FETCH_WIDTH'((1 << n) - 1))
            else report_error($sformatf("dispatch_valid %b not contiguous", dispatch_valid));
        assert (int'(fetch_credit_return) == n)
            else report_error($sformatf("fetch_credit_return %0d, lanes %0d",
                                        fetch_credit_return, n));
        assert (n <= min_of(int'(limit_used), FETCH_WIDTH))
            else report_error($sformatf("%0d lanes over limit %0d", n, limit_used));
        assert (n == expect_pop)
            else report_error($sformatf("dispatched %0d lanes, expected %0d", n, expect_pop));
        assert (n <= model_q.size())
            else report_error("dispatch with an empty model queue");

        for (int i = 0; i < n; i++) begin
            word = model_q.pop_front();
            predecode_model(word, cls, rd, rs1, operand);
            assert (dispatch_class[i*CLASS_WIDTH +: CLASS_WIDTH] == cls &&
                    dispatch_rd[i*REG_WIDTH +: REG_WIDTH] == rd &&
                    dispatch_rs1[i*REG_WIDTH +: REG_WIDTH] == rs1 &&
                    dispatch_operand[i*OPERAND_WIDTH +: OPERAND_WIDTH] == operand)
                else report_error($sformatf("lane %0d of word %h decoded wrong", i, word));
        end

        total_dispatched += n;
        occ_model        += push_seen - n;
        backend_held     += return_seen - n;
        backend_owed     += n;
        fetch_credits    += int'(fetch_credit_return);
        assert (backend_held >= 0)
            else report_error("back-end credit model went negative");
        assert (fetch_credits <= BUFFER_DEPTH)
            else report_error($sformatf("fetch holds %0d credits", fetch_credits));

        case (cfg_address)
            REG_DISPATCH_LIMIT:   expect_read = CFG_DATA_WIDTH'(limit_model);
            REG_DISPATCHED_COUNT: expect_read = CFG_DATA_WIDTH'(total_dispatched);
            REG_OCCUPANCY:        expect_read = CFG_DATA_WIDTH'(occ_model);
            default:              expect_read = '0;
        endcase
        assert (cfg_read_data == expect_read)
            else report_error($sformatf("register %0d read %0h, expected %0h",
                                        cfg_address, cfg_read_data, expect_read));
    endtask

    initial begin
        seed                  = 32'hdcb7_bc23;
        fetch_credits         = BUFFER_DEPTH;
        backend_held          = BACKEND_CREDITS;
        backend_owed          = 0;
        occ_model             = 0;
        total_dispatched      = 0;
        limit_model           = 3'd4;
        limit_used            = 3'd4;
        reset                 = 1'b1;
        inst_value            = '0;
        inst_valid            = '0;
        backend_credit_return = '0;
        cfg_write             = 1'b0;
        cfg_address           = REG_DISPATCH_LIMIT;
        cfg_write_data        = '0;

        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        assert (dispatch_valid == '0 && fetch_credit_return == '0)
            else report_error("outputs not idle after reset");
        assert (cfg_read_data == CFG_DATA_WIDTH'(4))
            else report_error($sformatf("limit reads %0d after reset", cfg_read_data));

        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(posedge clock);
            sample_inputs();
            drive_inputs(cyc);
            @(negedge clock);
            check_outputs();
        end

        // Drained queue gives every credit back
        assert (fetch_credits == BUFFER_DEPTH && occ_model == 0 && model_q.size() == 0)
            else report_error($sformatf("after drain fetch holds %0d credits", fetch_credits));

        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Simulation timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* compile.f */
frontend_pkg.sv
fetch_buffer.sv
inst_predecode.sv
dispatch_control.sv
frontend_config.sv
ria_frontend.sv
frontend_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module frontend_tb \
    -f compile.f -o frontend_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/frontend_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -eq 0 ] && grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
